// File: rtl/dac_serial_pkg.sv
//##########################################################################
// dac serial control package
// widths, types, pin bundle, state encoding and register map shared by
// the AD5668 DAC serial control path
//##########################################################################

package dac_serial_pkg;

  // three DAC groups on the board, three AD5668 per group
  localparam int N_DAC_GROUPS = 3;
  localparam int N_DAC_CHIPS = 3;
  // one AD5668 command frame
  localparam int FRAME_BITS = 32;
  localparam logic [15:0] FW_VERSION = 16'h0003;

  typedef logic [FRAME_BITS-1:0] dac_frame_t;
  typedef logic [N_DAC_GROUPS-1:0] group_sel_t;
  typedef logic [N_DAC_CHIPS-1:0] chip_sel_t;
  typedef logic [$clog2(FRAME_BITS)-1:0] bit_idx_t;
  typedef logic [7:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // transfer to come, as held by the register file
  typedef struct packed {
    dac_frame_t frame;
    group_sel_t group_sel;
    chip_sel_t chip_sel;
  } dac_cfg_t;

  // board pins, sync_n index is group * N_DAC_CHIPS + chip
  typedef struct packed {
    logic [N_DAC_GROUPS-1:0] sclk;
    logic [N_DAC_GROUPS-1:0] din;
    logic [N_DAC_GROUPS*N_DAC_CHIPS-1:0] sync_n;
  } dac_pins_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_SHIFT,
    ST_HOLD
  } spi_state_t;

  // byte offsets on the APB
  localparam apb_addr_t REG_VERSION = 8'h00;
  localparam apb_addr_t REG_GROUP_SEL = 8'h04;
  localparam apb_addr_t REG_CHIP_SEL = 8'h08;
  localparam apb_addr_t REG_DATA_HI = 8'h0C;
  localparam apb_addr_t REG_DATA_LO = 8'h10;
  localparam apb_addr_t REG_TASK = 8'h14;

endpackage

// File: rtl/dac_ctrl_regs.sv
//##########################################################################
// dac control registers
// APB slave holding the DAC group and chip selects, the two halves of the
// frame and the start/busy task register
//##########################################################################

module dac_ctrl_regs import dac_serial_pkg::*; (
  input  logic      i_lclk,
  input  logic      i_lclk_rst,
  input  logic      i_psel,
  input  logic      i_penable,
  input  logic      i_pwrite,
  input  apb_addr_t i_paddr,
  input  apb_data_t i_pwdata,
  input  logic      i_busy,
  output apb_data_t o_prdata,
  output logic      o_pready,
  output logic      o_pslverr,
  output dac_cfg_t  o_cfg,
  output logic      o_start
);

  localparam int HALF_BITS = FRAME_BITS / 2;

  logic access;
  logic mapped;
  logic locked;
  logic wr_en;
  group_sel_t group_sel_q;
  chip_sel_t chip_sel_q;
  logic [HALF_BITS-1:0] data_hi_q;
  logic [HALF_BITS-1:0] data_lo_q;
  logic start_q;

  // access phase of an APB transfer
  assign access = i_psel & i_penable;

  // address decode
  // locked registers refuse writes while a frame is in flight
  always_comb begin
    mapped = 1'b1;
    locked = 1'b1;
    case (i_paddr)
      REG_VERSION: begin
        locked = 1'b0;
      end
      REG_GROUP_SEL, REG_CHIP_SEL, REG_DATA_HI, REG_DATA_LO, REG_TASK: begin
        locked = 1'b1;
      end
      default: begin
        mapped = 1'b0;
        locked = 1'b0;
      end
    endcase
  end

  assign wr_en = access & i_pwrite & mapped & locked & ~i_busy;

  // zero wait states
  assign o_pready = 1'b1;
  // unmapped offset, or a write that lands while busy
  assign o_pslverr = access & (~mapped | (i_pwrite & locked & i_busy));

  // read mux, unmapped reads give 0
  always_comb begin
    o_prdata = '0;
    if (access && !i_pwrite) begin
      case (i_paddr)
        REG_VERSION: o_prdata = apb_data_t'(FW_VERSION);
        REG_GROUP_SEL: o_prdata = apb_data_t'(group_sel_q);
        REG_CHIP_SEL: o_prdata = apb_data_t'(chip_sel_q);
        REG_DATA_HI: o_prdata = apb_data_t'(data_hi_q);
        REG_DATA_LO: o_prdata = apb_data_t'(data_lo_q);
        // busy in bit 0
        REG_TASK: o_prdata = apb_data_t'(i_busy);
        default: o_prdata = '0;
      endcase
    end
  end

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      group_sel_q <= '0;
      chip_sel_q <= '0;
      data_hi_q <= '0;
      data_lo_q <= '0;
      start_q <= 1'b0;
    end else begin
      // start is a single cycle pulse
      start_q <= 1'b0;
      if (wr_en) begin
        case (i_paddr)
          REG_GROUP_SEL: group_sel_q <= i_pwdata[N_DAC_GROUPS-1:0];
          REG_CHIP_SEL: chip_sel_q <= i_pwdata[N_DAC_CHIPS-1:0];
          REG_DATA_HI: data_hi_q <= i_pwdata[HALF_BITS-1:0];
          REG_DATA_LO: data_lo_q <= i_pwdata[HALF_BITS-1:0];
          REG_TASK: start_q <= i_pwdata[0];
          default: start_q <= 1'b0;
        endcase
      end
    end
  end

  assign o_start = start_q;

  // frame high half sits in the upper 16 bits
  assign o_cfg = '{
    frame: {data_hi_q, data_lo_q},
    group_sel: group_sel_q,
    chip_sel: chip_sel_q
  };

endmodule

// File: rtl/dac_spi_fsm.sv
//##########################################################################
// dac spi sequencer
// steps one frame through setup, shift and hold on half period ticks and
// produces the sclk level, load and shift strobes
//##########################################################################

module dac_spi_fsm import dac_serial_pkg::*; (
  input  logic i_lclk,
  input  logic i_lclk_rst,
  input  logic i_start,
  input  logic i_half_tick,
  input  logic i_last_bit,
  output logic o_busy,
  output logic o_timer_run,
  output logic o_load,
  output logic o_shift,
  output logic o_sclk_level,
  output logic o_frame_active
);

  spi_state_t state_q;
  spi_state_t state_d;
  logic sclk_q;
  logic sclk_d;
  logic active;
  logic rise;

  // the start cycle already counts as the first setup cycle
  assign active = i_start | (state_q != ST_IDLE);
  // low half done, sclk about to rise
  assign rise = (state_q == ST_SHIFT) & ~sclk_q & i_half_tick;

  assign o_busy = active;
  assign o_timer_run = active;
  assign o_frame_active = active;
  assign o_load = i_start & (state_q == ST_IDLE);
  // next bit on each rise, none after bit 0
  assign o_shift = rise & ~i_last_bit;
  assign o_sclk_level = sclk_q;

  always_comb begin
    state_d = state_q;
    sclk_d = sclk_q;
    case (state_q)
      ST_IDLE: begin
        if (i_start) begin
          state_d = ST_SETUP;
        end
      end
      // sync low, sclk high, msb on din
      ST_SETUP: begin
        if (i_half_tick) begin
          state_d = ST_SHIFT;
        end
      end
      ST_SHIFT: begin
        if (i_half_tick) begin
          // falling edge, DAC samples here
          if (sclk_q) begin
            sclk_d = 1'b0;
          end else begin
            sclk_d = 1'b1;
            if (i_last_bit) begin
              state_d = ST_HOLD;
            end
          end
        end
      end
      // sclk high for one half period before sync rises
      ST_HOLD: begin
        if (i_half_tick) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      state_q <= ST_IDLE;
      sclk_q <= 1'b1;
    end else begin
      state_q <= state_d;
      sclk_q <= sclk_d;
    end
  end

endmodule

// File: rtl/dac_sclk_timer.sv
//##########################################################################
// sclk timer
// half period divider and bit counter pacing the spi sequencer
//##########################################################################

module dac_sclk_timer import dac_serial_pkg::*; #(
  parameter int P_SCLK_HALF = 4
) (
  input  logic i_lclk,
  input  logic i_lclk_rst,
  input  logic i_run,
  input  logic i_shift,
  output logic o_half_tick,
  output logic o_last_bit
);

  localparam int CNT_W = (P_SCLK_HALF > 1) ? $clog2(P_SCLK_HALF) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(P_SCLK_HALF - 1);

  logic [CNT_W-1:0] half_cnt_q;
  bit_idx_t bit_idx_q;

  // tick on the last cycle of each half period
  assign o_half_tick = i_run & (half_cnt_q == '0);
  // bit 0 of the frame is on din
  assign o_last_bit = (bit_idx_q == bit_idx_t'(FRAME_BITS - 1));

  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      half_cnt_q <= RELOAD;
      bit_idx_q <= '0;
    end else begin
      // held at reload while idle so the first half starts clean
      if (!i_run || half_cnt_q == '0) begin
        half_cnt_q <= RELOAD;
      end else begin
        half_cnt_q <= half_cnt_q - 1'b1;
      end
      // counts bits already shifted out
      if (!i_run) begin
        bit_idx_q <= '0;
      end else if (i_shift) begin
        bit_idx_q <= bit_idx_q + 1'b1;
      end
    end
  end

endmodule

// File: rtl/dac_frame_shifter.sv
//##########################################################################
// dac frame shifter
// shifts the frame out msb first and steers sclk, din and sync_n onto
// the selected DAC groups and chips
//##########################################################################

module dac_frame_shifter import dac_serial_pkg::*; (
  input  logic      i_lclk,
  input  logic      i_lclk_rst,
  input  dac_cfg_t  i_cfg,
  input  logic      i_load,
  input  logic      i_shift,
  input  logic      i_sclk_level,
  input  logic      i_frame_active,
  output dac_pins_t o_dac_pins
);

  dac_frame_t shreg_q;
  logic din_bit;
  dac_pins_t pins_q;

  // bit that will be on din next cycle
  always_comb begin
    if (i_load) begin
      din_bit = i_cfg.frame[FRAME_BITS-1];
    end else if (i_shift) begin
      din_bit = shreg_q[FRAME_BITS-2];
    end else begin
      din_bit = shreg_q[FRAME_BITS-1];
    end
  end

  // frame capture and left shift
  always_ff @(posedge i_lclk) begin
    if (i_load) begin
      shreg_q <= i_cfg.frame;
    end else if (i_shift) begin
      shreg_q <= {shreg_q[FRAME_BITS-2:0], 1'b0};
    end
  end

  // registered pins
  // unselected lines and idle time sit at sclk high, din low, sync_n high
  always_ff @(posedge i_lclk) begin
    if (i_lclk_rst) begin
      pins_q.sclk <= '1;
      pins_q.din <= '0;
      pins_q.sync_n <= '1;
    end else begin
      for (int g = 0; g < N_DAC_GROUPS; g++) begin
        pins_q.sclk[g] <= i_cfg.group_sel[g] ? i_sclk_level : 1'b1;
        pins_q.din[g] <= i_cfg.group_sel[g] & i_frame_active & din_bit;
        // one sync_n per chip of the group
        for (int c = 0; c < N_DAC_CHIPS; c++) begin
          pins_q.sync_n[g*N_DAC_CHIPS+c] <=
            ~(i_frame_active & i_cfg.group_sel[g] & i_cfg.chip_sel[c]);
        end
      end
    end
  end

  assign o_dac_pins = pins_q;

endmodule

// File: rtl/dac_serial_ctrl.sv
//##########################################################################
// dac serial control top
// APB controlled serial write path for the three AD5668 DAC groups
//##########################################################################

module dac_serial_ctrl import dac_serial_pkg::*; #(
  // lclk cycles per sclk half period, at least 2
  parameter int P_SCLK_HALF = 4
) (
  input  logic      i_lclk,
  input  logic      i_lclk_rst,
  input  logic      i_psel,
  input  logic      i_penable,
  input  logic      i_pwrite,
  input  apb_addr_t i_paddr,
  input  apb_data_t i_pwdata,
  output apb_data_t o_prdata,
  output logic      o_pready,
  output logic      o_pslverr,
  output dac_pins_t o_dac_pins
);

  // register file view of the next transfer
  dac_cfg_t cfg;
  logic start;
  logic busy;
  // sequencer strobes
  logic timer_run;
  logic load;
  logic shift;
  logic sclk_level;
  logic frame_active;
  // timer feedback
  logic half_tick;
  logic last_bit;

  dac_ctrl_regs regs_i (
    .i_lclk     (i_lclk),
    .i_lclk_rst (i_lclk_rst),
    .i_psel     (i_psel),
    .i_penable  (i_penable),
    .i_pwrite   (i_pwrite),
    .i_paddr    (i_paddr),
    .i_pwdata   (i_pwdata),
    .i_busy     (busy),
    .o_prdata   (o_prdata),
    .o_pready   (o_pready),
    .o_pslverr  (o_pslverr),
    .o_cfg      (cfg),
    .o_start    (start)
  );

  dac_spi_fsm fsm_i (
    .i_lclk         (i_lclk),
    .i_lclk_rst     (i_lclk_rst),
    .i_start        (start),
    .i_half_tick    (half_tick),
    .i_last_bit     (last_bit),
    .o_busy         (busy),
    .o_timer_run    (timer_run),
    .o_load         (load),
    .o_shift        (shift),
    .o_sclk_level   (sclk_level),
    .o_frame_active (frame_active)
  );

  dac_sclk_timer #(
    .P_SCLK_HALF (P_SCLK_HALF)
  ) timer_i (
    .i_lclk      (i_lclk),
    .i_lclk_rst  (i_lclk_rst),
    .i_run       (timer_run),
    .i_shift     (shift),
    .o_half_tick (half_tick),
    .o_last_bit  (last_bit)
  );

  dac_frame_shifter shifter_i (
    .i_lclk         (i_lclk),
    .i_lclk_rst     (i_lclk_rst),
    .i_cfg          (cfg),
    .i_load         (load),
    .i_shift        (shift),
    .i_sclk_level   (sclk_level),
    .i_frame_active (frame_active),
    .o_dac_pins     (o_dac_pins)
  );

endmodule

// File: verif/dac_serial_ctrl_checker.sv
//##########################################################################
// dac pin protocol checker
// concurrent assertions on the DAC pins and the APB ready line of the
// serial control top level
//##########################################################################

module dac_serial_ctrl_checker import dac_serial_pkg::*; (
  input logic      i_lclk,
  input logic      i_lclk_rst,
  input dac_cfg_t  i_cfg,
  input logic      i_busy,
  input logic      i_pready,
  input dac_pins_t i_pins
);

  timeunit 1ns;
  timeprecision 100ps;

  // assertion failures so far
  int unsigned fail_count = 0;

  for (genvar g = 0; g < N_DAC_GROUPS; g++) begin : g_group
    // unselected group keeps all its sync_n high
    a_sync_idle: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
      !i_cfg.group_sel[g] |-> &i_pins.sync_n[g*N_DAC_CHIPS +: N_DAC_CHIPS])
    else begin
      $error("sync_n low on unselected group %0d", g);
      fail_count++;
    end
    // sclk parked high, din low
    a_lines_idle: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
      !i_cfg.group_sel[g] |-> i_pins.sclk[g] && !i_pins.din[g])
    else begin
      $error("sclk or din active on unselected group %0d", g);
      fail_count++;
    end
  end

  // sync_n lags busy by one cycle, so settled from the third busy cycle
  a_sync_stable: assert property (@(posedge i_lclk) disable iff (i_lclk_rst)
    i_busy && $past(i_busy) && $past(i_busy, 2) |-> $stable(i_pins.sync_n))
  else begin
    $error("sync_n changed in mid-frame");
    fail_count++;
  end

  a_pready: assert property (@(posedge i_lclk) disable iff (i_lclk_rst) i_pready)
  else begin
    $error("pready low");
    fail_count++;
  end

endmodule

// File: verif/tb_dac_serial_ctrl.sv
//##########################################################################
// testbench for the dac serial control path
// APB accesses in, DAC pins decoded at each falling sclk and compared
// against a reference decode of the frame and selects
//##########################################################################

module tb_dac_serial_ctrl import dac_serial_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int H = 4;
  localparam int N_RAND = 16;
  localparam int N_SYNC = N_DAC_GROUPS * N_DAC_CHIPS;
  // start pulse to busy falling
  localparam int FRAME_CYCLES = (2 * FRAME_BITS + 2) * H;
  // each random frame counts as one test in the time budget
  localparam int N_BUDGET = N_RAND + 4;
  localparam dac_pins_t IDLE_PINS = {{N_DAC_GROUPS{1'b1}}, {N_DAC_GROUPS{1'b0}}, {N_SYNC{1'b1}}};

  // expected decode of one frame
  typedef struct packed {
    logic [N_DAC_GROUPS-1:0][FRAME_BITS-1:0] din;
    logic [N_DAC_GROUPS-1:0] clocked;
    logic [N_SYNC-1:0] sync_n;
  } frame_exp_t;

  logic lclk;
  logic lclk_rst;
  logic psel;
  logic penable;
  logic pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic pready;
  logic pslverr;
  dac_pins_t pins;
  logic busy;
  frame_exp_t exp_q;
  int frames_done = 0;
  int errors = 0;
  int tests = 0;
  int bad_tests = 0;
  int unsigned assert_fails;
  logic timed_out = 1'b0;
  logic [31:0] rng_state = 32'd95918;

  dac_serial_ctrl #(
    .P_SCLK_HALF (H)
  ) dut_i (
    .i_lclk     (lclk),
    .i_lclk_rst (lclk_rst),
    .i_psel     (psel),
    .i_penable  (penable),
    .i_pwrite   (pwrite),
    .i_paddr    (paddr),
    .i_pwdata   (pwdata),
    .o_prdata   (prdata),
    .o_pready   (pready),
    .o_pslverr  (pslverr),
    .o_dac_pins (pins)
  );

  bind dac_serial_ctrl dac_serial_ctrl_checker checker_i (
    .i_lclk     (i_lclk),
    .i_lclk_rst (i_lclk_rst),
    .i_cfg      (cfg),
    .i_busy     (busy),
    .i_pready   (o_pready),
    .i_pins     (o_dac_pins)
  );

  // frame window taken from inside the DUT
  assign busy = dut_i.busy;

  initial begin
    lclk = 1'b0;
    forever #2 lclk = ~lclk;
  end

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  // selected groups get all 32 bits msb first
  // sync_n low only where group and chip are both selected
  function automatic frame_exp_t expect_frame(dac_frame_t frame, group_sel_t gsel,
                                              chip_sel_t csel);
    frame_exp_t e;
    e = '0;
    e.sync_n = '1;
    for (int g = 0; g < N_DAC_GROUPS; g++) begin
      if (gsel[g]) begin
        e.din[g] = frame;
        e.clocked[g] = 1'b1;
        for (int c = 0; c < N_DAC_CHIPS; c++) begin
          e.sync_n[g*N_DAC_CHIPS+c] = ~csel[c];
        end
      end
    end
    return e;
  endfunction

  // one zero wait state APB transfer with a setup and an access phase
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    @(negedge lclk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = write;
    paddr = addr;
    pwdata = wdata;
    @(negedge lclk);
    penable = 1'b1;
    // sampled mid access phase before the completing edge
    #1;
    rdata = prdata;
    err = pslverr;
    @(negedge lclk);
    psel = 1'b0;
    penable = 1'b0;
  endtask

  // write that has to come back with the given pslverr
  task automatic check_write(input apb_addr_t addr, input apb_data_t data,
                             input logic exp_err);
    apb_data_t rdata;
    logic err;
    apb_access(1'b1, addr, data, rdata, err);
    if (err !== exp_err) begin
      $display("Fail pslverr[0x%h]: got 0x%h expected 0x%h", addr, err, exp_err);
      errors++;
    end
  endtask

  task automatic check_read(input apb_addr_t addr, input apb_data_t expected);
    apb_data_t d;
    logic err;
    apb_access(1'b0, addr, '0, d, err);
    if (err !== 1'b0) begin
      $display("Fail pslverr[0x%h]: got 0x%h expected 0x%h", addr, err, 1'b0);
      errors++;
    end
    if (d !== expected) begin
      $display("Fail prdata[0x%h]: got 0x%h expected 0x%h", addr, d, expected);
      errors++;
    end
  endtask

  // task register reads idle too
  task automatic check_regs(input group_sel_t gsel, input chip_sel_t csel, input dac_frame_t f);
    check_read(REG_GROUP_SEL, apb_data_t'(gsel));
    check_read(REG_CHIP_SEL, apb_data_t'(csel));
    check_read(REG_DATA_HI, apb_data_t'(f[31:16]));
    check_read(REG_DATA_LO, apb_data_t'(f[15:0]));
    check_read(REG_TASK, 32'h0);
  endtask

  task automatic check_unmapped(input apb_addr_t addr);
    apb_data_t d;
    logic err;
    apb_access(1'b0, addr, '0, d, err);
    if (err !== 1'b1) begin
      $display("Fail pslverr[0x%h]: got 0x%h expected 0x%h", addr, err, 1'b1);
      errors++;
    end
    if (d !== 32'h0) begin
      $display("Fail prdata[0x%h]: got 0x%h expected 0x%h", addr, d, 32'h0);
      errors++;
    end
    check_write(addr, 32'hFFFF_FFFF, 1'b1);
  endtask

  // load selects and frame, then kick the task register
  task automatic start_frame(input dac_frame_t frame, input group_sel_t gsel,
                             input chip_sel_t csel, output int count);
    exp_q = expect_frame(frame, gsel, csel);
    check_write(REG_GROUP_SEL, apb_data_t'(gsel), 1'b0);
    check_write(REG_CHIP_SEL, apb_data_t'(csel), 1'b0);
    check_write(REG_DATA_HI, apb_data_t'(frame[31:16]), 1'b0);
    check_write(REG_DATA_LO, apb_data_t'(frame[15:0]), 1'b0);
    count = frames_done;
    check_write(REG_TASK, 32'h1, 1'b0);
  endtask

  // wait for the monitor to close the frame, then pins back to idle
  task automatic finish_frame(input int count);
    int waited;
    waited = 0;
    while (frames_done == count && !timed_out) begin
      @(negedge lclk);
      waited++;
      if (waited > 2 * FRAME_CYCLES) begin
        $display("frame did not complete, busy never dropped");
        timed_out = 1'b1;
      end
    end
    repeat (2) @(negedge lclk);
    if (pins != IDLE_PINS) begin
      $display("Fail dac_pins: got 0x%h expected 0x%h", pins, IDLE_PINS);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int e0);
    tests++;
    if (errors == e0) begin
      $display("%s: ok", name);
    end else begin
      bad_tests++;
      $display("%s: %0d errors", name, errors - e0);
    end
  endtask

  // pin decode compared at the end of every frame
  initial begin : monitor
    logic [N_DAC_GROUPS-1:0] sclk_prev;
    logic busy_prev;
    dac_frame_t cap [N_DAC_GROUPS];
    int nbits [N_DAC_GROUPS];
    logic [N_SYNC-1:0] sync_low;
    int busy_cnt;
    sclk_prev = '1;
    busy_prev = 1'b0;
    sync_low = '0;
    busy_cnt = 0;
    for (int g = 0; g < N_DAC_GROUPS; g++) begin
      cap[g] = '0;
      nbits[g] = 0;
    end
    forever begin
      @(negedge lclk);
      if (!lclk_rst) begin
        // the DAC samples din on the falling sclk
        for (int g = 0; g < N_DAC_GROUPS; g++) begin
          if (sclk_prev[g] && !pins.sclk[g]) begin
            cap[g] = {cap[g][FRAME_BITS-2:0], pins.din[g]};
            nbits[g]++;
          end
        end
        if (busy) begin
          busy_cnt++;
          sync_low |= ~pins.sync_n;
        end
        if (busy_prev && !busy) begin
          for (int g = 0; g < N_DAC_GROUPS; g++) begin
            if (nbits[g] != (exp_q.clocked[g] ? FRAME_BITS : 0)) begin
              $display("Fail sclk_falls[%0d]: got 0x%h expected 0x%h", g, nbits[g],
                       exp_q.clocked[g] ? FRAME_BITS : 0);
              errors++;
            end
            if (cap[g] != exp_q.din[g]) begin
              $display("Fail din[%0d]: got 0x%h expected 0x%h", g, cap[g], exp_q.din[g]);
              errors++;
            end
            cap[g] = '0;
            nbits[g] = 0;
          end
          if (~sync_low != exp_q.sync_n) begin
            $display("Fail sync_n: got 0x%h expected 0x%h", ~sync_low, exp_q.sync_n);
            errors++;
          end
          if (busy_cnt != FRAME_CYCLES) begin
            $display("Fail busy_cycles: got 0x%h expected 0x%h", busy_cnt, FRAME_CYCLES);
            errors++;
          end
          sync_low = '0;
          busy_cnt = 0;
          frames_done++;
        end
        sclk_prev = pins.sclk;
        busy_prev = busy;
      end
    end
  end

  initial begin : main
    int n;
    int e0;
    dac_frame_t frame;
    logic [31:0] r;
    lclk_rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (2) @(negedge lclk);
    lclk_rst = 1'b0;

    e0 = errors;
    check_read(REG_VERSION, 32'h0000_0003);
    check_regs('0, '0, '0);
    if (pins != IDLE_PINS) begin
      $display("Fail dac_pins: got 0x%h expected 0x%h", pins, IDLE_PINS);
      errors++;
    end
    finish_test("reset values", e0);

    e0 = errors;
    start_frame(32'hA5C3_1E69, 3'b001, 3'b010, n);
    finish_frame(n);
    finish_test("single frame group 0 chip 1", e0);

    e0 = errors;
    for (int i = 0; i < N_RAND && !timed_out; i++) begin
      frame = next_random();
      r = next_random();
      // selects never zero
      start_frame(frame, group_sel_t'(r % 7 + 1), chip_sel_t'((r >> 8) % 7 + 1), n);
      finish_frame(n);
    end
    finish_test("random frames", e0);

    // every locked register refused while the frame runs
    e0 = errors;
    frame = 32'h3C96_F00D;
    start_frame(frame, 3'b110, 3'b101, n);
    check_read(REG_TASK, 32'h1);
    for (int i = 0; i < 5; i++) begin
      check_write(apb_addr_t'(REG_GROUP_SEL + 4 * i), 32'hFFFF_FFFF, 1'b1);
    end
    finish_frame(n);
    check_regs(3'b110, 3'b101, frame);
    finish_test("writes while busy", e0);

    e0 = errors;
    check_unmapped(8'h18);
    check_unmapped(8'h02);
    check_unmapped(8'hFC);
    check_regs(3'b110, 3'b101, frame);
    finish_test("unmapped offsets", e0);

    assert_fails = dut_i.checker_i.fail_count;
    $display("tests %0d, tests with errors %0d, errors %0d, assertion failures %0d",
             tests, bad_tests, errors, assert_fails);
    if (errors == 0 && !timed_out && assert_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // 4 ns per cycle and twice the expected run length
  initial begin : watchdog
    #(N_BUDGET * (FRAME_CYCLES + 20) * 4 * 2);
    $display("simulation ran past its time budget and was stopped");
    $display("Test failed");
    $finish;
  end

endmodule

// File: dac_serial_ctrl.f
rtl/dac_serial_pkg.sv
rtl/dac_ctrl_regs.sv
rtl/dac_spi_fsm.sv
rtl/dac_sclk_timer.sv
rtl/dac_frame_shifter.sv
rtl/dac_serial_ctrl.sv
verif/dac_serial_ctrl_checker.sv
verif/tb_dac_serial_ctrl.sv

// File: Makefile
# Verilator simulation of the DAC serial control path

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_dac_serial_ctrl -f dac_serial_ctrl.f -Mdir obj_dir
	./obj_dir/Vtb_dac_serial_ctrl +verilator+error+limit+1000 | tee sim.log
	grep -q '^Test passed$$' sim.log

clean:
	rm -rf obj_dir sim.log
